//--- design/alu_unit.sv
/* ALU and ALU control */

module alu_unit (
	input  mips_pkg::alu_op_t alu_op,
	input  logic [5:0]        funct,
	input  mips_pkg::word_t   a,
	input  mips_pkg::word_t   b,
	output mips_pkg::word_t   result,
	output logic              zero
);

	mips_pkg::alu_sel_t sel;

	always_comb begin
		case (alu_op)
			mips_pkg::alu_op_sub:   sel = mips_pkg::sel_sub;
			mips_pkg::alu_op_funct: begin
				case (funct)
					mips_pkg::fn_sub: sel = mips_pkg::sel_sub;
					mips_pkg::fn_and: sel = mips_pkg::sel_and;
					mips_pkg::fn_or:  sel = mips_pkg::sel_or;
					mips_pkg::fn_slt: sel = mips_pkg::sel_slt;
					default:          sel = mips_pkg::sel_add; // fn_add and others
				endcase
			end
			default: sel = mips_pkg::sel_add;
		endcase
	end

	always_comb begin
		case (sel)
			mips_pkg::sel_sub: result = a - b;
			mips_pkg::sel_and: result = a & b;
			mips_pkg::sel_or:  result = a | b;
			mips_pkg::sel_slt: result = {31'b0, $signed(a) < $signed(b)}; // Signed
			default:           result = a + b;
		endcase
	end

	assign zero = (result == '0);

endmodule

//--- design/ctrl_if.sv
/* Decode control bundle */

interface ctrl_if;

	logic                  reg_write;  // Result goes to the register file
	logic                  mem_to_reg; // Writeback from memory, not ALU
	logic                  branch;
	logic                  mem_read;
	logic                  mem_write;
	logic                  reg_dst;    // rd as destination, else rt
	mips_pkg::alu_op_t     alu_op;
	logic                  alu_src;    // Immediate as ALU operand b

	modport decoder (
		output reg_write, mem_to_reg, branch, mem_read,
		output mem_write, reg_dst, alu_op, alu_src
	);

	modport pipeline (
		input reg_write, mem_to_reg, branch, mem_read,
		input mem_write, reg_dst, alu_op, alu_src
	);

endinterface

//--- design/hazard_unit.sv
/* Stall and flush detection */

module hazard_unit (
	input  mips_pkg::reg_idx_t rs,
	input  mips_pkg::reg_idx_t rt,
	input  mips_pkg::reg_idx_t ex_dest,
	input  logic               ex_reg_write,
	input  mips_pkg::reg_idx_t mem_dest,
	input  logic               mem_reg_write,
	input  logic               branch_taken,
	output logic               stall,
	output logic               flush
);

	logic rs_hit;
	logic rt_hit;

	// Register zero never carries a dependence
	assign rs_hit = (rs != '0) &&
		((ex_reg_write && (rs == ex_dest)) || (mem_reg_write && (rs == mem_dest)));
	assign rt_hit = (rt != '0) &&
		((ex_reg_write && (rt == ex_dest)) || (mem_reg_write && (rt == mem_dest)));

	// WB writes pass through the register file, so no check against WB

	assign flush = branch_taken;
	assign stall = (rs_hit || rt_hit) && !branch_taken; // Flush wins

endmodule

//--- design/id_control.sv
/* Decode stage main control */

module id_control (
	input  mips_pkg::word_t instr,
	input  logic            noop,  // Bubble request from hazard handling
	ctrl_if.decoder         ctrl
);

	mips_pkg::opcode_t opcode;

	assign opcode = noop ? mips_pkg::op_nop : instr[31:26];

	always_comb begin
		// Everything inactive unless the opcode says otherwise
		ctrl.reg_write  = 1'b0;
		ctrl.mem_to_reg = 1'b0;
		ctrl.branch     = 1'b0;
		ctrl.mem_read   = 1'b0;
		ctrl.mem_write  = 1'b0;
		ctrl.reg_dst    = 1'b0;
		ctrl.alu_op     = mips_pkg::alu_op_add;
		ctrl.alu_src    = 1'b0;

		case (opcode)
			mips_pkg::op_rtype: begin
				ctrl.reg_dst   = 1'b1;
				ctrl.alu_op    = mips_pkg::alu_op_funct;
				ctrl.reg_write = 1'b1;
			end
			mips_pkg::op_lw: begin
				ctrl.alu_src    = 1'b1;
				ctrl.mem_read   = 1'b1;
				ctrl.reg_write  = 1'b1;
				ctrl.mem_to_reg = 1'b1;
			end
			mips_pkg::op_sw: begin
				ctrl.alu_src   = 1'b1;
				ctrl.mem_write = 1'b1; // reg_dst is a don't care here
			end
			mips_pkg::op_beq: begin
				ctrl.alu_op = mips_pkg::alu_op_sub;
				ctrl.branch = 1'b1;
			end
			default: begin
				// op_nop and undefined opcodes keep the inactive values
			end
		endcase
	end

endmodule

//--- design/mips_pipeline.sv
/* Five-stage MIPS pipeline */

module mips_pipeline #(
	parameter int pc_bits = 8 // Word address bits of instruction space
) (
	input  logic            clk,
	input  logic            arst_n,
	output mips_pkg::word_t instr_addr,
	input  mips_pkg::word_t instr,
	output mips_pkg::word_t dmem_addr,
	output mips_pkg::word_t dmem_wdata,
	output logic            dmem_we,
	input  mips_pkg::word_t dmem_rdata,
	output logic            wb_en,
	output mips_pkg::reg_idx_t wb_reg,
	output mips_pkg::word_t wb_data
);

	// IF
	logic [pc_bits-1:0] pc;     // Word index
	mips_pkg::word_t    pc_byte;
	mips_pkg::word_t    pc4;

	// IF/ID
	logic               if_id_valid;
	mips_pkg::word_t    if_id_instr;
	mips_pkg::word_t    if_id_pc4;

	// ID
	ctrl_if             id_ctrl ();
	logic               id_noop;
	logic               stall;
	logic               flush;
	mips_pkg::reg_idx_t id_rs;
	mips_pkg::reg_idx_t id_rt;
	mips_pkg::reg_idx_t id_dest;
	mips_pkg::word_t    id_rs_data;
	mips_pkg::word_t    id_rt_data;
	mips_pkg::word_t    id_imm;

	// ID/EX
	logic               id_ex_reg_write;
	logic               id_ex_mem_to_reg;
	logic               id_ex_branch;
	logic               id_ex_mem_read;
	logic               id_ex_mem_write;
	mips_pkg::alu_op_t  id_ex_alu_op;
	logic               id_ex_alu_src;
	mips_pkg::word_t    id_ex_rs_data;
	mips_pkg::word_t    id_ex_rt_data;
	mips_pkg::word_t    id_ex_imm;
	mips_pkg::word_t    id_ex_pc4;
	logic [5:0]         id_ex_funct;
	mips_pkg::reg_idx_t id_ex_dest;

	// EX
	mips_pkg::word_t    alu_b;
	mips_pkg::word_t    alu_result;
	logic               alu_zero;
	logic               branch_taken;
	mips_pkg::word_t    branch_target;

	// EX/MEM
	logic               ex_mem_reg_write;
	logic               ex_mem_mem_to_reg;
	logic               ex_mem_mem_read;
	logic               ex_mem_mem_write;
	mips_pkg::word_t    ex_mem_alu;
	mips_pkg::word_t    ex_mem_wdata;
	mips_pkg::reg_idx_t ex_mem_dest;

	// MEM/WB
	logic               mem_wb_reg_write;
	logic               mem_wb_mem_to_reg;
	mips_pkg::word_t    mem_wb_alu;
	mips_pkg::word_t    mem_wb_rdata;
	mips_pkg::reg_idx_t mem_wb_dest;

	assign pc_byte    = mips_pkg::word_t'({pc, 2'b00});
	assign pc4        = pc_byte + 32'd4;
	assign instr_addr = pc_byte;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (flush) begin
			pc <= branch_target[pc_bits+1:2];
		end else if (!stall) begin
			pc <= pc + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_id_valid <= 1'b0;
		end else if (flush) begin
			if_id_valid <= 1'b0; // Younger instruction killed
		end else if (!stall) begin
			if_id_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			if_id_instr <= instr;
			if_id_pc4   <= pc4;
		end
	end

	// Invalid slot reads nothing, so it cannot stall
	assign id_rs   = if_id_valid ? if_id_instr[25:21] : '0;
	assign id_rt   = if_id_valid ? if_id_instr[20:16] : '0;
	assign id_noop = stall || flush || !if_id_valid;
	assign id_imm  = {{16{if_id_instr[15]}}, if_id_instr[15:0]};
	assign id_dest = id_ctrl.reg_dst ? if_id_instr[15:11] : if_id_instr[20:16];

	id_control u_id_control (
		.instr (if_id_instr),
		.noop  (id_noop),
		.ctrl  (id_ctrl.decoder)
	);

	hazard_unit u_hazard_unit (
		.rs            (id_rs),
		.rt            (id_rt),
		.ex_dest       (id_ex_dest),
		.ex_reg_write  (id_ex_reg_write),
		.mem_dest      (ex_mem_dest),
		.mem_reg_write (ex_mem_reg_write),
		.branch_taken  (branch_taken),
		.stall         (stall),
		.flush         (flush)
	);

	reg_file u_reg_file (
		.clk     (clk),
		.arst_n  (arst_n),
		.rs      (id_rs),
		.rt      (id_rt),
		.rs_data (id_rs_data),
		.rt_data (id_rt_data),
		.we      (wb_en),
		.wr_reg  (wb_reg),
		.wr_data (wb_data)
	);

	// Control already zeroed by the decoder on stall or flush
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_ex_reg_write  <= 1'b0;
			id_ex_mem_to_reg <= 1'b0;
			id_ex_branch     <= 1'b0;
			id_ex_mem_read   <= 1'b0;
			id_ex_mem_write  <= 1'b0;
			id_ex_alu_op     <= mips_pkg::alu_op_add;
			id_ex_alu_src    <= 1'b0;
		end else begin
			id_ex_reg_write  <= id_ctrl.reg_write;
			id_ex_mem_to_reg <= id_ctrl.mem_to_reg;
			id_ex_branch     <= id_ctrl.branch;
			id_ex_mem_read   <= id_ctrl.mem_read;
			id_ex_mem_write  <= id_ctrl.mem_write;
			id_ex_alu_op     <= id_ctrl.alu_op;
			id_ex_alu_src    <= id_ctrl.alu_src;
		end
	end

	always_ff @(posedge clk) begin
		id_ex_rs_data <= id_rs_data;
		id_ex_rt_data <= id_rt_data;
		id_ex_imm     <= id_imm;
		id_ex_pc4     <= if_id_pc4;
		id_ex_funct   <= if_id_instr[5:0];
		id_ex_dest    <= id_dest;
	end

	assign alu_b = id_ex_alu_src ? id_ex_imm : id_ex_rt_data;

	alu_unit u_alu_unit (
		.alu_op (id_ex_alu_op),
		.funct  (id_ex_funct),
		.a      (id_ex_rs_data),
		.b      (alu_b),
		.result (alu_result),
		.zero   (alu_zero)
	);

	assign branch_taken  = id_ex_branch && alu_zero;
	assign branch_target = id_ex_pc4 + {id_ex_imm[29:0], 2'b00};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem_reg_write  <= 1'b0;
			ex_mem_mem_to_reg <= 1'b0;
			ex_mem_mem_read   <= 1'b0;
			ex_mem_mem_write  <= 1'b0;
		end else begin
			ex_mem_reg_write  <= id_ex_reg_write;
			ex_mem_mem_to_reg <= id_ex_mem_to_reg;
			ex_mem_mem_read   <= id_ex_mem_read;
			ex_mem_mem_write  <= id_ex_mem_write;
		end
	end

	always_ff @(posedge clk) begin
		ex_mem_alu   <= alu_result;
		ex_mem_wdata <= id_ex_rt_data; // Store data
		ex_mem_dest  <= id_ex_dest;
	end

	assign dmem_addr  = ex_mem_alu;
	assign dmem_wdata = ex_mem_wdata;
	assign dmem_we    = ex_mem_mem_write;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_wb_reg_write  <= 1'b0;
			mem_wb_mem_to_reg <= 1'b0;
		end else begin
			mem_wb_reg_write  <= ex_mem_reg_write;
			mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
		end
	end

	always_ff @(posedge clk) begin
		mem_wb_alu  <= ex_mem_alu;
		mem_wb_dest <= ex_mem_dest;
		if (ex_mem_mem_read) begin
			mem_wb_rdata <= dmem_rdata; // Only loads sample memory
		end
	end

	assign wb_en   = mem_wb_reg_write && (mem_wb_dest != '0);
	assign wb_reg  = mem_wb_dest;
	assign wb_data = mem_wb_mem_to_reg ? mem_wb_rdata : mem_wb_alu;

endmodule

//--- design/mips_pkg.sv
/* MIPS subset shared definitions */

package mips_pkg;

	typedef logic [31:0] word_t;    // Data or instruction word
	typedef logic [4:0]  reg_idx_t; // Register number
	typedef logic [5:0]  opcode_t;  // Instruction bits 31:26

	// Main opcodes
	localparam opcode_t op_rtype = 6'b000000;
	localparam opcode_t op_lw    = 6'b100011;
	localparam opcode_t op_sw    = 6'b101011;
	localparam opcode_t op_beq   = 6'b000100;
	localparam opcode_t op_nop   = 6'b100000; // Substituted for bubbles

	// R-type funct field codes
	localparam logic [5:0] fn_add = 6'b100000;
	localparam logic [5:0] fn_sub = 6'b100010;
	localparam logic [5:0] fn_and = 6'b100100;
	localparam logic [5:0] fn_or  = 6'b100101;
	localparam logic [5:0] fn_slt = 6'b101010;

	// ALUOp from the main decoder
	typedef logic [1:0] alu_op_t;

	localparam alu_op_t alu_op_add   = 2'b00; // lw and sw address
	localparam alu_op_t alu_op_sub   = 2'b01; // beq compare
	localparam alu_op_t alu_op_funct = 2'b10; // R-type decodes the funct field

	// Concrete ALU operation
	typedef enum logic [2:0] {
		sel_add,
		sel_sub,
		sel_and,
		sel_or,
		sel_slt
	} alu_sel_t;

endpackage

//--- design/reg_file.sv
/* Register file */

module reg_file (
	input  logic               clk,
	input  logic               arst_n,
	input  mips_pkg::reg_idx_t rs,
	input  mips_pkg::reg_idx_t rt,
	output mips_pkg::word_t    rs_data,
	output mips_pkg::word_t    rt_data,
	input  logic               we,
	input  mips_pkg::reg_idx_t wr_reg,
	input  mips_pkg::word_t    wr_data
);

	mips_pkg::word_t regs [32];

	logic wr_live; // A write that actually lands

	assign wr_live = we && (wr_reg != '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[wr_reg] <= wr_data;
		end
	end

	// Same-cycle write shows up on the read ports
	assign rs_data = (wr_live && (wr_reg == rs)) ? wr_data : regs[rs];
	assign rt_data = (wr_live && (wr_reg == rt)) ? wr_data : regs[rt];

endmodule

//--- run.sh
#!/bin/sh
# Build and run the MIPS pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_mips -o Vtb_mips
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_mips)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1

//--- sources.f
design/mips_pkg.sv
design/ctrl_if.sv
design/id_control.sv
design/hazard_unit.sv
design/reg_file.sv
design/alu_unit.sv
design/mips_pipeline.sv
tb/tb_mips.sv

//--- tb/tb_mips.sv
/* MIPS pipeline testbench */

module tb_mips;

	localparam int prog_len   = 200;
	localparam int imem_words = 256;
	localparam int dmem_words = 64;
	localparam int timeout    = prog_len * 8 * 4 + 400;
	localparam logic [31:0] end_addr = 32'((prog_len - 1) * 4); // Final self loop

	logic               clk;
	logic               arst_n;
	mips_pkg::word_t    instr_addr;
	mips_pkg::word_t    instr;
	mips_pkg::word_t    dmem_addr;
	mips_pkg::word_t    dmem_wdata;
	logic               dmem_we;
	mips_pkg::word_t    dmem_rdata;
	logic               wb_en;
	mips_pkg::reg_idx_t wb_reg;
	mips_pkg::word_t    wb_data;

	logic [31:0] imem [imem_words];
	logic [31:0] dmem [dmem_words];
	logic [31:0] model_mem [dmem_words];
	logic [31:0] model_regs [32];

	// Expected retirement order from the ISA model
	logic [4:0]  exp_wr_reg [$];
	logic [31:0] exp_wr_data [$];
	logic [31:0] exp_st_addr [$];
	logic [31:0] exp_st_data [$];

	int wr_seen;
	int st_seen;
	int wb_errors;
	int store_errors;
	int other_errors;

	mips_pipeline #(
		.pc_bits (8)
	) DUT (
		.clk        (clk),
		.arst_n     (arst_n),
		.instr_addr (instr_addr),
		.instr      (instr),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_rdata (dmem_rdata),
		.wb_en      (wb_en),
		.wb_reg     (wb_reg),
		.wb_data    (wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] encode_rtype(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [5:0] funct);
		return {mips_pkg::op_rtype, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] encode_itype(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic build_program();
		int kind;
		int off;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [5:0] op;
		logic [5:0] funct;
		for (int i = 0; i < prog_len - 1; i++) begin
			kind = $urandom_range(0, 99);
			rs = 5'($urandom_range(0, 7)); // Few registers give many dependences
			rt = 5'($urandom_range(0, 7));
			rd = 5'($urandom_range(0, 7));
			if (kind < 50) begin
				case ($urandom_range(0, 4))
					0:       funct = mips_pkg::fn_add;
					1:       funct = mips_pkg::fn_sub;
					2:       funct = mips_pkg::fn_and;
					3:       funct = mips_pkg::fn_or;
					default: funct = mips_pkg::fn_slt;
				endcase
				imem[i] = encode_rtype(rs, rt, rd, funct);
			end else if (kind < 65) begin
				imem[i] = encode_itype(mips_pkg::op_lw, 5'd0, rt,
					16'($urandom_range(0, dmem_words - 1) * 4));
			end else if (kind < 80) begin
				imem[i] = encode_itype(mips_pkg::op_sw, 5'd0, rt,
					16'($urandom_range(0, dmem_words - 1) * 4));
			end else if (kind < 92) begin
				off = $urandom_range(0, 3);
				if (i + 1 + off > prog_len - 1) begin
					off = prog_len - 2 - i; // Stay inside the program
				end
				if ($urandom_range(0, 1) == 1) begin
					rt = rs; // Taken for sure
				end
				imem[i] = encode_itype(mips_pkg::op_beq, rs, rt, 16'(off));
			end else begin
				op = 6'($urandom_range(0, 63));
				while (op == mips_pkg::op_rtype || op == mips_pkg::op_lw ||
						op == mips_pkg::op_sw || op == mips_pkg::op_beq ||
						op == mips_pkg::op_nop) begin
					op = 6'($urandom_range(0, 63));
				end
				imem[i] = {op, 26'($urandom)};
			end
		end
		imem[prog_len - 1] = encode_itype(mips_pkg::op_beq, 5'd0, 5'd0, 16'hffff);
		for (int i = prog_len; i < imem_words; i++) begin
			imem[i] = {6'h3f, 26'(i)}; // Undefined opcode, never retires
		end
		for (int i = 0; i < dmem_words; i++) begin
			dmem[i] = $urandom;
			model_mem[i] = dmem[i];
		end
	endtask

	task automatic record_write(input logic [4:0] rd, input logic [31:0] value);
		if (rd != 5'd0) begin
			model_regs[rd] = value;
			exp_wr_reg.push_back(rd);
			exp_wr_data.push_back(value);
		end
	endtask

	// In-order ISA reference
	task automatic run_model();
		int pc;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] addr;
		pc = 0;
		for (int r = 0; r < 32; r++) begin
			model_regs[r] = '0;
		end
		while (pc != prog_len - 1) begin
			ins  = imem[pc];
			a    = model_regs[ins[25:21]];
			b    = model_regs[ins[20:16]];
			addr = a + {{16{ins[15]}}, ins[15:0]};
			pc   = pc + 1;
			case (ins[31:26])
				mips_pkg::op_rtype: begin
					case (ins[5:0])
						mips_pkg::fn_sub: res = a - b;
						mips_pkg::fn_and: res = a & b;
						mips_pkg::fn_or:  res = a | b;
						mips_pkg::fn_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default:          res = a + b;
					endcase
					record_write(ins[15:11], res);
				end
				mips_pkg::op_lw: record_write(ins[20:16], model_mem[addr[7:2]]);
				mips_pkg::op_sw: begin
					model_mem[addr[7:2]] = b;
					exp_st_addr.push_back(addr);
					exp_st_data.push_back(b);
				end
				mips_pkg::op_beq: begin
					if (a == b) begin
						pc = pc + int'($signed(ins[15:0]));
					end
				end
				default: begin
				end
			endcase
		end
	endtask

	task automatic check_quiet();
		if (wb_en !== 1'b0) begin
			$display("CHECK FAILED wb_en: got %h, expected %h", wb_en, 1'b0);
			wb_errors++;
		end
		if (dmem_we !== 1'b0) begin
			$display("CHECK FAILED dmem_we: got %h, expected %h", dmem_we, 1'b0);
			store_errors++;
		end
	endtask

	task automatic check_write();
		if (wr_seen >= exp_wr_reg.size()) begin
			$display("Register write to r%0d arrived after all expected writes", wb_reg);
			other_errors++;
		end else begin
			if (wb_reg !== exp_wr_reg[wr_seen]) begin
				$display("CHECK FAILED wb_reg: got %h, expected %h",
					wb_reg, exp_wr_reg[wr_seen]);
				wb_errors++;
			end
			if (wb_data !== exp_wr_data[wr_seen]) begin
				$display("CHECK FAILED wb_data: got %h, expected %h",
					wb_data, exp_wr_data[wr_seen]);
				wb_errors++;
			end
		end
		wr_seen++;
	endtask

	task automatic check_store();
		if (st_seen >= exp_st_addr.size()) begin
			$display("Store to address %h arrived after all expected stores", dmem_addr);
			other_errors++;
		end else begin
			if (dmem_addr !== exp_st_addr[st_seen]) begin
				$display("CHECK FAILED dmem_addr: got %h, expected %h",
					dmem_addr, exp_st_addr[st_seen]);
				store_errors++;
			end
			if (dmem_wdata !== exp_st_data[st_seen]) begin
				$display("CHECK FAILED dmem_wdata: got %h, expected %h",
					dmem_wdata, exp_st_data[st_seen]);
				store_errors++;
			end
		end
		st_seen++;
	endtask

	// Memory service and retirement checks on the falling edge
	initial begin
		instr      = '0;
		dmem_rdata = '0;
		forever begin
			@(negedge clk);
			if (wb_en === 1'b1) begin
				check_write();
			end
			if (dmem_we === 1'b1) begin
				check_store();
				dmem[dmem_addr[7:2]] = dmem_wdata;
			end
			instr      = imem[instr_addr[9:2]];
			dmem_rdata = dmem[dmem_addr[7:2]];
		end
	end

	initial begin
		#(timeout);
		$display("Timeout: the program did not reach its final loop in %0d time units", timeout);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		arst_n       = 1'b0;
		wr_seen      = 0;
		st_seen      = 0;
		wb_errors    = 0;
		store_errors = 0;
		other_errors = 0;
		void'($urandom(32'h63a8cba9));
		build_program();
		run_model();

		repeat (2) begin
			@(negedge clk);
			check_quiet();
		end
		arst_n = 1'b1;
		@(negedge clk);
		check_quiet(); // First cycle out of reset

		while (instr_addr !== end_addr) begin
			@(negedge clk);
		end
		repeat (16) @(negedge clk); // Let older instructions drain

		if (wr_seen < exp_wr_reg.size()) begin
			$display("%0d expected register writes never appeared",
				exp_wr_reg.size() - wr_seen);
			other_errors++;
		end
		if (st_seen < exp_st_addr.size()) begin
			$display("%0d expected stores never appeared", exp_st_addr.size() - st_seen);
			other_errors++;
		end

		$display("Errors: writes %0d, stores %0d, other %0d (%0d writes, %0d stores seen)",
			wb_errors, store_errors, other_errors, wr_seen, st_seen);
		if (wb_errors + store_errors + other_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
